//--- common/xcvr_rcfg_pkg.sv
// Shared widths, CSR address map and bus types for the reconfiguration hub
// CSR offsets are 9-bit channel addresses seen with address bit 9 set
// Packed struct fields are listed MSB first, so the last field is bit 0
`default_nettype none

package xcvr_rcfg_pkg;

  localparam int NUM_CHANNELS    = 4;
  localparam int ADDR_BITS       = 10;
  localparam int SEL_BITS        = 2;
  localparam int USER_DATA_WIDTH = 32;
  localparam int PHY_DATA_WIDTH  = 8;
  localparam int COUNT_WIDTH     = 50;
  localparam int CSR_SEL_BIT     = 9;

  // Snapshot counts are read as seven bytes, least significant first
  localparam int PRBS_SNAP_BYTES = 7;

  typedef logic [ADDR_BITS-1:0]          chan_addr_t;
  typedef logic [ADDR_BITS+SEL_BITS-1:0] user_addr_t;
  typedef logic [SEL_BITS-1:0]           chan_sel_t;
  typedef logic [USER_DATA_WIDTH-1:0]    user_data_t;
  typedef logic [PHY_DATA_WIDTH-1:0]     phy_data_t;
  typedef logic [COUNT_WIDTH-1:0]        prbs_count_t;

  localparam phy_data_t CSR_ID_VALUE = 8'hA5;

  localparam logic [CSR_SEL_BIT-1:0] CSR_ADDR_ID            = 9'h000;
  localparam logic [CSR_SEL_BIT-1:0] CSR_ADDR_CHANNEL       = 9'h001;
  localparam logic [CSR_SEL_BIT-1:0] CSR_ADDR_STATUS        = 9'h010;
  localparam logic [CSR_SEL_BIT-1:0] CSR_ADDR_OVR_EN        = 9'h012;
  localparam logic [CSR_SEL_BIT-1:0] CSR_ADDR_OVR_VAL       = 9'h013;
  localparam logic [CSR_SEL_BIT-1:0] CSR_ADDR_CAL_MASK      = 9'h014;
  localparam logic [CSR_SEL_BIT-1:0] CSR_ADDR_PRBS_CTRL     = 9'h020;
  localparam logic [CSR_SEL_BIT-1:0] CSR_ADDR_PRBS_ERR_BASE = 9'h021;
  localparam logic [CSR_SEL_BIT-1:0] CSR_ADDR_PRBS_BIT_BASE = 9'h028;

  typedef struct packed {
    logic       write;
    logic       read;
    user_addr_t address;
    user_data_t writedata;
  } user_req_t;

  typedef struct packed {
    logic       write;
    logic       read;
    chan_addr_t address;
    phy_data_t  writedata;
  } chan_req_t;

  typedef struct packed {
    logic rx_cal_busy;
    logic tx_cal_busy;
    logic rx_is_lockedtodata;
    logic rx_is_lockedtoref;
  } phy_status_t;

  typedef struct packed {
    logic tx_digitalreset;
    logic tx_analogreset;
    logic rx_digitalreset;
    logic rx_analogreset;
    logic en_serial_lpbk;
    logic set_rx_locktodata;
    logic set_rx_locktoref;
  } phy_ctrl_t;

  typedef struct packed {
    logic rx_cal_busy_mask;
    logic tx_cal_busy_mask;
  } cal_mask_t;

  typedef struct packed {
    logic count_en;
    logic err_clr;
    logic snap;
  } prbs_ctrl_t;

endpackage

`default_nettype wire

//--- hw/prbs/prbs_accum.sv
// PRBS bit and error accumulator of one channel
// err and done are synchronized together, two cycles of latency
// Counters run while count_en and the synced done are high, 50 bits wide
// Counters wrap silently, snapshots hold until the next snap
`timescale 1ns/1ps
`default_nettype none

module prbs_accum (
  input  wire                          reconfig_clk,
  input  wire                          reset,
  input  xcvr_rcfg_pkg::prbs_ctrl_t    prbs_ctrl,
  input  wire                          prbs_err,
  input  wire                          prbs_done,
  output logic                         prbs_done_sync,
  output xcvr_rcfg_pkg::prbs_count_t   prbs_err_snap,
  output xcvr_rcfg_pkg::prbs_count_t   prbs_bit_snap
);

  // Bit 1 carries err, bit 0 carries done
  logic [1:0] sync_meta_q;
  logic [1:0] sync_q;
  logic       err_sync;
  logic       count_cycle;

  xcvr_rcfg_pkg::prbs_count_t err_cnt_q;
  xcvr_rcfg_pkg::prbs_count_t bit_cnt_q;

  // Both inputs share one two-flop stage so they stay aligned
  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      sync_meta_q <= 2'b00;
      sync_q      <= 2'b00;
    end else begin
      sync_meta_q <= {prbs_err, prbs_done};
      sync_q      <= sync_meta_q;
    end
  end

  assign err_sync       = sync_q[1];
  assign prbs_done_sync = sync_q[0];
  assign count_cycle    = prbs_ctrl.count_en & prbs_done_sync;

  always_ff @(posedge reconfig_clk) begin
    if (reset || prbs_ctrl.err_clr) begin
      err_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (count_cycle) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
      if (err_sync) begin
        err_cnt_q <= err_cnt_q + 1'b1;
      end
    end
  end

  // Snapshot lands one cycle after the snap pulse
  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      prbs_err_snap <= '0;
      prbs_bit_snap <= '0;
    end else if (prbs_ctrl.snap) begin
      prbs_err_snap <= err_cnt_q;
      prbs_bit_snap <= bit_cnt_q;
    end
  end

endmodule

`default_nettype wire

//--- hw/csr/soft_csr.sv
// Soft CSR block of one channel
// Writes complete in one cycle, reads stall one cycle and return registered data
// Override bits replace the matching ctrl_in bit while enabled
// err_clr and snap are one-cycle pulses from a PRBS_CTRL write
`timescale 1ns/1ps
`default_nettype none

module soft_csr #(
  parameter int channel_num = 0
) (
  input  wire                          reconfig_clk,
  input  wire                          reset,

  // Request with read and write already qualified by the CSR select
  input  xcvr_rcfg_pkg::chan_req_t     csr_req,
  output xcvr_rcfg_pkg::phy_data_t     csr_readdata,
  output logic                         csr_waitrequest,

  input  xcvr_rcfg_pkg::phy_status_t   status_in,
  input  xcvr_rcfg_pkg::phy_ctrl_t     ctrl_in,
  output xcvr_rcfg_pkg::phy_ctrl_t     ctrl_out,
  output xcvr_rcfg_pkg::cal_mask_t     cal_mask,

  // PRBS accumulator interface
  input  wire                          prbs_done_sync,
  input  xcvr_rcfg_pkg::prbs_count_t   prbs_err_snap,
  input  xcvr_rcfg_pkg::prbs_count_t   prbs_bit_snap,
  output xcvr_rcfg_pkg::prbs_ctrl_t    prbs_ctrl
);

  logic [xcvr_rcfg_pkg::CSR_SEL_BIT-1:0]         csr_addr;
  logic [xcvr_rcfg_pkg::CSR_SEL_BIT-1:0]         err_off;
  logic [xcvr_rcfg_pkg::CSR_SEL_BIT-1:0]         bit_off;
  logic [xcvr_rcfg_pkg::PRBS_SNAP_BYTES*8-1:0]   err_ext;
  logic [xcvr_rcfg_pkg::PRBS_SNAP_BYTES*8-1:0]   bit_ext;

  xcvr_rcfg_pkg::phy_ctrl_t  ovr_en_q;
  xcvr_rcfg_pkg::phy_ctrl_t  ovr_val_q;
  xcvr_rcfg_pkg::cal_mask_t  cal_mask_q;
  logic                      count_en_q;
  logic                      err_clr_q;
  logic                      snap_q;

  logic                      rd_valid_q;
  xcvr_rcfg_pkg::phy_data_t  rd_data_q;
  xcvr_rcfg_pkg::phy_data_t  rd_next;

  assign csr_addr = csr_req.address[xcvr_rcfg_pkg::CSR_SEL_BIT-1:0];

  // Register writes
  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      ovr_en_q   <= '0;
      ovr_val_q  <= '0;
      cal_mask_q <= '1;
      count_en_q <= 1'b0;
      err_clr_q  <= 1'b0;
      snap_q     <= 1'b0;
    end else begin
      err_clr_q <= 1'b0;
      snap_q    <= 1'b0;
      if (csr_req.write) begin
        case (csr_addr)
          xcvr_rcfg_pkg::CSR_ADDR_OVR_EN: begin
            ovr_en_q <= xcvr_rcfg_pkg::phy_ctrl_t'(csr_req.writedata[6:0]);
          end
          xcvr_rcfg_pkg::CSR_ADDR_OVR_VAL: begin
            ovr_val_q <= xcvr_rcfg_pkg::phy_ctrl_t'(csr_req.writedata[6:0]);
          end
          xcvr_rcfg_pkg::CSR_ADDR_CAL_MASK: begin
            cal_mask_q <= xcvr_rcfg_pkg::cal_mask_t'(csr_req.writedata[1:0]);
          end
          xcvr_rcfg_pkg::CSR_ADDR_PRBS_CTRL: begin
            count_en_q <= csr_req.writedata[0];
            err_clr_q  <= csr_req.writedata[1];
            snap_q     <= csr_req.writedata[2];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Enabled bits take the override value, the rest follow the PHY inputs
  assign ctrl_out = xcvr_rcfg_pkg::phy_ctrl_t'((ovr_en_q & ovr_val_q) | (~ovr_en_q & ctrl_in));
  assign cal_mask = cal_mask_q;

  assign prbs_ctrl.count_en = count_en_q;
  assign prbs_ctrl.err_clr  = err_clr_q;
  assign prbs_ctrl.snap     = snap_q;

  // Snapshot counts padded to whole bytes
  assign err_ext = {{(xcvr_rcfg_pkg::PRBS_SNAP_BYTES*8-xcvr_rcfg_pkg::COUNT_WIDTH){1'b0}},
                    prbs_err_snap};
  assign bit_ext = {{(xcvr_rcfg_pkg::PRBS_SNAP_BYTES*8-xcvr_rcfg_pkg::COUNT_WIDTH){1'b0}},
                    prbs_bit_snap};

  // Offsets wrap below the base, so one compare covers the range
  assign err_off = csr_addr - xcvr_rcfg_pkg::CSR_ADDR_PRBS_ERR_BASE;
  assign bit_off = csr_addr - xcvr_rcfg_pkg::CSR_ADDR_PRBS_BIT_BASE;

  always_comb begin
    rd_next = '0;
    case (csr_addr)
      xcvr_rcfg_pkg::CSR_ADDR_ID:        rd_next = xcvr_rcfg_pkg::CSR_ID_VALUE;
      xcvr_rcfg_pkg::CSR_ADDR_CHANNEL:   rd_next = xcvr_rcfg_pkg::phy_data_t'(channel_num);
      xcvr_rcfg_pkg::CSR_ADDR_STATUS:    rd_next = {4'b0000, status_in};
      xcvr_rcfg_pkg::CSR_ADDR_OVR_EN:    rd_next = {1'b0, ovr_en_q};
      xcvr_rcfg_pkg::CSR_ADDR_OVR_VAL:   rd_next = {1'b0, ovr_val_q};
      xcvr_rcfg_pkg::CSR_ADDR_CAL_MASK:  rd_next = {6'b000000, cal_mask_q};
      xcvr_rcfg_pkg::CSR_ADDR_PRBS_CTRL: rd_next = {4'b0000, prbs_done_sync, 2'b00, count_en_q};
      default: begin
        if (err_off < xcvr_rcfg_pkg::PRBS_SNAP_BYTES) begin
          rd_next = err_ext[err_off[2:0]*8 +: 8];
        end else if (bit_off < xcvr_rcfg_pkg::PRBS_SNAP_BYTES) begin
          rd_next = bit_ext[bit_off[2:0]*8 +: 8];
        end
      end
    endcase
  end

  // First read cycle stalls and captures, second returns the data
  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= csr_req.read & ~rd_valid_q;
    end
  end

  always_ff @(posedge reconfig_clk) begin
    if (csr_req.read && !rd_valid_q) begin
      rd_data_q <= rd_next;
    end
  end

  assign csr_readdata    = rd_data_q;
  assign csr_waitrequest = csr_req.read & ~rd_valid_q;

endmodule

`default_nettype wire

//--- hw/xcvr_rcfg_channel.sv
// One channel of the hub
// Channel address bit 9 set targets the soft CSR, clear targets the PHY bus
// PHY accesses keep the PHY waitrequest timing unchanged
`timescale 1ns/1ps
`default_nettype none

module xcvr_rcfg_channel #(
  parameter int channel_num = 0
) (
  input  wire                          reconfig_clk,
  input  wire                          reset,

  // Channel request from the router
  input  xcvr_rcfg_pkg::chan_req_t     chan_req,
  output xcvr_rcfg_pkg::phy_data_t     chan_readdata,
  output logic                         chan_waitrequest,

  // PHY register bus
  output xcvr_rcfg_pkg::chan_req_t     phy_req,
  input  xcvr_rcfg_pkg::phy_data_t     phy_readdata,
  input  wire                          phy_waitrequest,

  // Status, control and PRBS
  input  xcvr_rcfg_pkg::phy_status_t   status_in,
  input  xcvr_rcfg_pkg::phy_ctrl_t     ctrl_in,
  input  wire                          prbs_err,
  input  wire                          prbs_done,
  output xcvr_rcfg_pkg::phy_ctrl_t     ctrl_out,
  output xcvr_rcfg_pkg::cal_mask_t     cal_mask,
  output logic                         prbs_err_clr
);

  logic                        csr_hit;
  xcvr_rcfg_pkg::chan_req_t    csr_req;
  xcvr_rcfg_pkg::phy_data_t    csr_readdata;
  logic                        csr_waitrequest;
  xcvr_rcfg_pkg::prbs_ctrl_t   prbs_ctrl;
  logic                        prbs_done_sync;
  xcvr_rcfg_pkg::prbs_count_t  prbs_err_snap;
  xcvr_rcfg_pkg::prbs_count_t  prbs_bit_snap;

  assign csr_hit = chan_req.address[xcvr_rcfg_pkg::CSR_SEL_BIT];

  // Strobes go to one target only
  always_comb begin
    csr_req       = chan_req;
    csr_req.read  = chan_req.read & csr_hit;
    csr_req.write = chan_req.write & csr_hit;
    phy_req       = chan_req;
    phy_req.read  = chan_req.read & ~csr_hit;
    phy_req.write = chan_req.write & ~csr_hit;
  end

  assign chan_readdata    = csr_hit ? csr_readdata : phy_readdata;
  assign chan_waitrequest = csr_hit ? csr_waitrequest : phy_waitrequest;

  assign prbs_err_clr = prbs_ctrl.err_clr;

  soft_csr #(
    .channel_num (channel_num)
  ) soft_csr_i (
    .reconfig_clk    (reconfig_clk),
    .reset           (reset),
    .csr_req         (csr_req),
    .status_in       (status_in),
    .ctrl_in         (ctrl_in),
    .prbs_done_sync  (prbs_done_sync),
    .prbs_err_snap   (prbs_err_snap),
    .prbs_bit_snap   (prbs_bit_snap),
    .csr_readdata    (csr_readdata),
    .csr_waitrequest (csr_waitrequest),
    .ctrl_out        (ctrl_out),
    .cal_mask        (cal_mask),
    .prbs_ctrl       (prbs_ctrl)
  );

  prbs_accum prbs_accum_i (
    .reconfig_clk   (reconfig_clk),
    .reset          (reset),
    .prbs_ctrl      (prbs_ctrl),
    .prbs_err       (prbs_err),
    .prbs_done      (prbs_done),
    .prbs_done_sync (prbs_done_sync),
    .prbs_err_snap  (prbs_err_snap),
    .prbs_bit_snap  (prbs_bit_snap)
  );

endmodule

`default_nettype wire

//--- hw/rcfg_channel_router.sv
// Splits the shared user port into one request per channel
// Purely combinational, the top address bits select the channel
// Write data is cut to the 8-bit channel bus, read data is zero-extended
`timescale 1ns/1ps
`default_nettype none

module rcfg_channel_router (
  input  xcvr_rcfg_pkg::user_req_t              user_req,
  input  xcvr_rcfg_pkg::phy_data_t              chan_readdata [xcvr_rcfg_pkg::NUM_CHANNELS],
  input  wire  [xcvr_rcfg_pkg::NUM_CHANNELS-1:0] chan_waitrequest,
  output xcvr_rcfg_pkg::chan_req_t              chan_req      [xcvr_rcfg_pkg::NUM_CHANNELS],
  output xcvr_rcfg_pkg::user_data_t             reconfig_readdata,
  output logic                                  reconfig_waitrequest
);

  xcvr_rcfg_pkg::chan_sel_t  chan_sel;
  xcvr_rcfg_pkg::chan_addr_t chan_addr;
  xcvr_rcfg_pkg::phy_data_t  sel_readdata;

  assign chan_sel  = user_req.address[xcvr_rcfg_pkg::ADDR_BITS +: xcvr_rcfg_pkg::SEL_BITS];
  assign chan_addr = user_req.address[xcvr_rcfg_pkg::ADDR_BITS-1:0];

  // Address and data fan out, only the selected channel sees the strobes
  for (genvar ch = 0; ch < xcvr_rcfg_pkg::NUM_CHANNELS; ch++) begin : g_split
    logic hit;

    assign hit = (chan_sel == xcvr_rcfg_pkg::chan_sel_t'(ch));

    assign chan_req[ch].write     = user_req.write & hit;
    assign chan_req[ch].read      = user_req.read & hit;
    assign chan_req[ch].address   = chan_addr;
    assign chan_req[ch].writedata = user_req.writedata[xcvr_rcfg_pkg::PHY_DATA_WIDTH-1:0];
  end

  // Return path from the selected channel
  assign sel_readdata         = chan_readdata[chan_sel];
  assign reconfig_readdata    = xcvr_rcfg_pkg::user_data_t'(sel_readdata);
  assign reconfig_waitrequest = chan_waitrequest[chan_sel];

endmodule

`default_nettype wire

//--- hw/xcvr_rcfg_hub.sv
// Reconfiguration hub for a four channel transceiver block
// One shared Avalon-MM style port, single clock, synchronous active high reset
// Master holds read or write until waitrequest is low
// PRBS err and done may be asynchronous, they are synchronized per channel
`timescale 1ns/1ps
`default_nettype none

module xcvr_rcfg_hub (
  input  wire                                   reconfig_clk,
  input  wire                                   reset,

  // Shared user port
  input  xcvr_rcfg_pkg::user_req_t              user_req,
  output xcvr_rcfg_pkg::user_data_t             reconfig_readdata,
  output logic                                  reconfig_waitrequest,

  // PHY register bus, one per channel
  output xcvr_rcfg_pkg::chan_req_t              phy_req         [xcvr_rcfg_pkg::NUM_CHANNELS],
  input  xcvr_rcfg_pkg::phy_data_t              phy_readdata    [xcvr_rcfg_pkg::NUM_CHANNELS],
  input  wire  [xcvr_rcfg_pkg::NUM_CHANNELS-1:0] phy_waitrequest,

  // PRBS checker outputs
  input  wire  [xcvr_rcfg_pkg::NUM_CHANNELS-1:0] prbs_err,
  input  wire  [xcvr_rcfg_pkg::NUM_CHANNELS-1:0] prbs_done,

  // Status and control
  input  xcvr_rcfg_pkg::phy_status_t            status_in       [xcvr_rcfg_pkg::NUM_CHANNELS],
  input  xcvr_rcfg_pkg::phy_ctrl_t              ctrl_in         [xcvr_rcfg_pkg::NUM_CHANNELS],
  output xcvr_rcfg_pkg::phy_ctrl_t              ctrl_out        [xcvr_rcfg_pkg::NUM_CHANNELS],
  output xcvr_rcfg_pkg::cal_mask_t              cal_mask        [xcvr_rcfg_pkg::NUM_CHANNELS],
  output logic [xcvr_rcfg_pkg::NUM_CHANNELS-1:0] prbs_err_clr
);

  xcvr_rcfg_pkg::chan_req_t              chan_req         [xcvr_rcfg_pkg::NUM_CHANNELS];
  xcvr_rcfg_pkg::phy_data_t              chan_readdata    [xcvr_rcfg_pkg::NUM_CHANNELS];
  logic [xcvr_rcfg_pkg::NUM_CHANNELS-1:0] chan_waitrequest;

  rcfg_channel_router rcfg_channel_router_i (
    .user_req             (user_req),
    .chan_readdata        (chan_readdata),
    .chan_waitrequest     (chan_waitrequest),
    .chan_req             (chan_req),
    .reconfig_readdata    (reconfig_readdata),
    .reconfig_waitrequest (reconfig_waitrequest)
  );

  for (genvar ch = 0; ch < xcvr_rcfg_pkg::NUM_CHANNELS; ch++) begin : g_channel
    xcvr_rcfg_channel #(
      .channel_num (ch)
    ) xcvr_rcfg_channel_i (
      .reconfig_clk     (reconfig_clk),
      .reset            (reset),
      .chan_req         (chan_req[ch]),
      .phy_readdata     (phy_readdata[ch]),
      .phy_waitrequest  (phy_waitrequest[ch]),
      .status_in        (status_in[ch]),
      .ctrl_in          (ctrl_in[ch]),
      .prbs_err         (prbs_err[ch]),
      .prbs_done        (prbs_done[ch]),
      .chan_readdata    (chan_readdata[ch]),
      .chan_waitrequest (chan_waitrequest[ch]),
      .phy_req          (phy_req[ch]),
      .ctrl_out         (ctrl_out[ch]),
      .cal_mask         (cal_mask[ch]),
      .prbs_err_clr     (prbs_err_clr[ch])
    );
  end

endmodule

`default_nettype wire

//--- tests/phy_avmm_model.sv
// Behavioral PHY register file of one channel, 1024 bytes
// Every access holds waitrequest high for two cycles, then completes
// Reset fills the memory with a pattern built from the whole address
`timescale 1ns/1ps
`default_nettype none

module phy_avmm_model (
  input  wire                        reconfig_clk,
  input  wire                        reset,
  input  xcvr_rcfg_pkg::chan_req_t   phy_req,
  output xcvr_rcfg_pkg::phy_data_t   phy_readdata,
  output logic                       phy_waitrequest
);

  localparam int MEM_DEPTH   = 2 ** xcvr_rcfg_pkg::ADDR_BITS;
  localparam int WAIT_CYCLES = 2;

  xcvr_rcfg_pkg::phy_data_t mem [MEM_DEPTH];
  logic [1:0]               wait_cnt_q;
  logic                     access;

  function automatic xcvr_rcfg_pkg::phy_data_t fill_byte(input int addr);
    return 8'(addr) ^ 8'(addr >> 2) ^ 8'h3C;
  endfunction

  assign access          = phy_req.read | phy_req.write;
  assign phy_waitrequest = access & (wait_cnt_q != WAIT_CYCLES);
  assign phy_readdata    = mem[phy_req.address];

  // Stall counter restarts once an access completes
  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      wait_cnt_q <= '0;
    end else if (phy_waitrequest) begin
      wait_cnt_q <= wait_cnt_q + 1'b1;
    end else begin
      wait_cnt_q <= '0;
    end
  end

  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
        mem[i] <= fill_byte(i);
      end
    end else if (phy_req.write && !phy_waitrequest) begin
      mem[phy_req.address] <= phy_req.writedata;
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_xcvr_rcfg_hub.sv
// Directed testbench for the reconfiguration hub
// Inputs change on the falling edge, outputs are read 1 ns later
// Four behavioral PHY models answer with a fixed two cycle stall
`timescale 1ns/1ps
`default_nettype none

module tb_xcvr_rcfg_hub;

  localparam int NCH = xcvr_rcfg_pkg::NUM_CHANNELS;
  localparam int RANDOM_SEED = 52556;
  // Whole run needs well under 2000 cycles, about six cycles per access
  localparam int TIMEOUT_CYCLES = 20000;

  logic                         reconfig_clk;
  logic                         reset;
  xcvr_rcfg_pkg::user_req_t     user_req;
  xcvr_rcfg_pkg::user_data_t    reconfig_readdata;
  logic                         reconfig_waitrequest;
  xcvr_rcfg_pkg::chan_req_t     phy_req [NCH];
  wire xcvr_rcfg_pkg::phy_data_t phy_readdata [NCH];
  wire [NCH-1:0]                phy_waitrequest;
  logic [NCH-1:0]               prbs_err;
  logic [NCH-1:0]               prbs_done;
  xcvr_rcfg_pkg::phy_status_t   status_in [NCH];
  xcvr_rcfg_pkg::phy_ctrl_t     ctrl_in [NCH];
  xcvr_rcfg_pkg::phy_ctrl_t     ctrl_out [NCH];
  xcvr_rcfg_pkg::cal_mask_t     cal_mask [NCH];
  logic [NCH-1:0]               prbs_err_clr;
  int                           cycle_count;
  int                           clr_pulses [NCH];
  int unsigned                  seed_value;

  xcvr_rcfg_hub xcvr_rcfg_hub_i (
    .reconfig_clk, .reset, .user_req, .reconfig_readdata, .reconfig_waitrequest,
    .phy_req, .phy_readdata, .phy_waitrequest, .prbs_err, .prbs_done,
    .status_in, .ctrl_in, .ctrl_out, .cal_mask, .prbs_err_clr
  );

  for (genvar ch = 0; ch < NCH; ch++) begin : g_phy
    phy_avmm_model phy_avmm_model_i (
      .reconfig_clk    (reconfig_clk),
      .reset           (reset),
      .phy_req         (phy_req[ch]),
      .phy_readdata    (phy_readdata[ch]),
      .phy_waitrequest (phy_waitrequest[ch])
    );
  end

  initial begin
    reconfig_clk = 1'b0;
    forever #5 reconfig_clk = ~reconfig_clk;
  end

  always @(posedge reconfig_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: no test end after %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped by timeout");
    end
  end

  // PHY strobes only for a PHY address of the selected channel
  always @(posedge reconfig_clk) begin
    for (int ch = 0; ch < NCH; ch++) begin
      if ((phy_req[ch].read || phy_req[ch].write) &&
          (user_req.address[xcvr_rcfg_pkg::CSR_SEL_BIT] ||
           user_req.address[xcvr_rcfg_pkg::ADDR_BITS +: xcvr_rcfg_pkg::SEL_BITS] !=
           xcvr_rcfg_pkg::chan_sel_t'(ch))) begin
        $display("PHY port of channel %0d strobed by a request it does not serve", ch);
        $display("Result: FAILED");
        $fatal(1, "Stopped at unexpected PHY access");
      end
    end
  end

  // Pulses are counted mid-cycle where the output is stable
  always @(negedge reconfig_clk) begin
    for (int ch = 0; ch < NCH; ch++) begin
      if (prbs_err_clr[ch]) clr_pulses[ch]++;
    end
  end

  task automatic report_mismatch(input string what, input string got, input string exp);
    $display("Error at %0t ns: %s got %s expected %s", $time, what, got, exp);
    $display("Result: FAILED");
    $fatal(1, "Stopped at first mismatch");
  endtask

  task automatic check_data(input xcvr_rcfg_pkg::user_data_t actual,
                            input xcvr_rcfg_pkg::user_data_t expected, input string what);
    if (actual !== expected) begin
      report_mismatch(what, $sformatf("%h", actual), $sformatf("%h", expected));
    end
  endtask

  task automatic check_ctrl(input xcvr_rcfg_pkg::phy_ctrl_t actual,
                            input xcvr_rcfg_pkg::phy_ctrl_t expected, input string what);
    if (actual !== expected) begin
      report_mismatch(what, $sformatf("%b", actual), $sformatf("%b", expected));
    end
  endtask

  task automatic check_mask(input xcvr_rcfg_pkg::cal_mask_t actual,
                            input xcvr_rcfg_pkg::cal_mask_t expected, input string what);
    if (actual !== expected) begin
      report_mismatch(what, $sformatf("%b", actual), $sformatf("%b", expected));
    end
  endtask

  function automatic xcvr_rcfg_pkg::user_addr_t make_phy_addr(input int ch, input int off);
    return {xcvr_rcfg_pkg::chan_sel_t'(ch), 1'b0, 9'(off)};
  endfunction

  function automatic xcvr_rcfg_pkg::user_addr_t make_csr_addr(input int ch, input int off);
    return {xcvr_rcfg_pkg::chan_sel_t'(ch), 1'b1, 9'(off)};
  endfunction

  // Hierarchical peek into a model memory
  function automatic xcvr_rcfg_pkg::phy_data_t phy_mem_byte(input int ch, input int addr);
    case (ch)
      0: return g_phy[0].phy_avmm_model_i.mem[addr];
      1: return g_phy[1].phy_avmm_model_i.mem[addr];
      2: return g_phy[2].phy_avmm_model_i.mem[addr];
      default: return g_phy[3].phy_avmm_model_i.mem[addr];
    endcase
  endfunction

  // Request stays up until waitrequest is seen low, then drops after the edge
  task automatic user_access(input logic is_write, input xcvr_rcfg_pkg::user_addr_t addr,
                             input xcvr_rcfg_pkg::user_data_t wdata,
                             output xcvr_rcfg_pkg::user_data_t rdata);
    bit accepted;
    accepted = 1'b0;
    @(negedge reconfig_clk);
    user_req.write     = is_write;
    user_req.read      = ~is_write;
    user_req.address   = addr;
    user_req.writedata = wdata;
    while (!accepted) begin
      #1;
      if (!reconfig_waitrequest) begin
        accepted = 1'b1;
        rdata    = reconfig_readdata;
      end
      @(negedge reconfig_clk);
    end
    user_req.write = 1'b0;
    user_req.read  = 1'b0;
  endtask

  task automatic user_write(input xcvr_rcfg_pkg::user_addr_t addr,
                            input xcvr_rcfg_pkg::user_data_t data);
    xcvr_rcfg_pkg::user_data_t unused;
    user_access(1'b1, addr, data, unused);
  endtask

  task automatic user_read(input xcvr_rcfg_pkg::user_addr_t addr,
                           output xcvr_rcfg_pkg::user_data_t data);
    user_access(1'b0, addr, '0, data);
  endtask

  task automatic test_phy_passthrough();
    int ch;
    int addr;
    xcvr_rcfg_pkg::user_data_t wdata;
    xcvr_rcfg_pkg::user_data_t rdata;
    for (int n = 0; n < 16; n++) begin
      ch    = $urandom % NCH;
      addr  = $urandom % 512;
      wdata = $urandom;
      user_write(make_phy_addr(ch, addr), wdata);
      user_read(make_phy_addr(ch, addr), rdata);
      check_data(rdata, {24'h0, wdata[7:0]}, "PHY readback");
      check_data({24'h0, phy_mem_byte(ch, addr)}, {24'h0, wdata[7:0]}, "PHY model memory");
    end
  endtask

  task automatic test_channel_isolation();
    int addr;
    logic [7:0] bytes [NCH];
    xcvr_rcfg_pkg::user_data_t rdata;
    addr = $urandom % 512;
    for (int ch = 0; ch < NCH; ch++) begin
      bytes[ch] = 8'($urandom);
      user_write(make_phy_addr(ch, addr), {24'($urandom), bytes[ch]});
    end
    for (int ch = 0; ch < NCH; ch++) begin
      user_read(make_phy_addr(ch, addr), rdata);
      check_data(rdata, {24'h0, bytes[ch]}, "Channel isolation readback");
    end
  endtask

  task automatic test_csr_identity();
    logic [31:0] r;
    xcvr_rcfg_pkg::user_data_t rdata;
    for (int ch = 0; ch < NCH; ch++) begin
      user_read(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_ID), rdata);
      check_data(rdata, 32'h0000_00A5, "CSR ID");
      user_read(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_CHANNEL), rdata);
      check_data(rdata, 32'(ch), "CSR channel index");
      repeat (3) begin
        r = $urandom;
        @(negedge reconfig_clk);
        status_in[ch].rx_is_lockedtoref  = r[0];
        status_in[ch].rx_is_lockedtodata = r[1];
        status_in[ch].tx_cal_busy        = r[2];
        status_in[ch].rx_cal_busy        = r[3];
        user_read(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_STATUS), rdata);
        check_data(rdata, {28'h0, r[3:0]}, "CSR status");
      end
    end
  endtask

  task automatic test_ctrl_override();
    logic [6:0] en;
    logic [6:0] val;
    logic [6:0] in_bits;
    logic [6:0] exp_bits;
    logic [1:0] mask;
    xcvr_rcfg_pkg::phy_ctrl_t expected;
    xcvr_rcfg_pkg::cal_mask_t exp_mask;
    @(negedge reconfig_clk);
    for (int ch = 0; ch < NCH; ch++) ctrl_in[ch] = 7'($urandom);
    #1;
    exp_mask.tx_cal_busy_mask = 1'b1;
    exp_mask.rx_cal_busy_mask = 1'b1;
    for (int ch = 0; ch < NCH; ch++) begin
      check_ctrl(ctrl_out[ch], ctrl_in[ch], "ctrl_out without override");
      check_mask(cal_mask[ch], exp_mask, "cal_mask after reset");
    end
    for (int ch = 0; ch < NCH; ch++) begin
      en  = 7'($urandom);
      val = 7'($urandom);
      user_write(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_OVR_EN), {25'h0, en});
      user_write(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_OVR_VAL), {25'h0, val});
      // New inputs show that bits without override still follow ctrl_in
      ctrl_in[ch] = 7'($urandom);
      #1;
      in_bits = ctrl_in[ch];
      for (int b = 0; b < 7; b++) begin
        if (en[b]) begin
          exp_bits[b] = val[b];
        end else begin
          exp_bits[b] = in_bits[b];
        end
      end
      expected = exp_bits;
      check_ctrl(ctrl_out[ch], expected, "ctrl_out with override");
      mask = 2'($urandom);
      user_write(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_CAL_MASK), {30'h0, mask});
      exp_mask.tx_cal_busy_mask = mask[0];
      exp_mask.rx_cal_busy_mask = mask[1];
      check_mask(cal_mask[ch], exp_mask, "cal_mask after write");
    end
  endtask

  task automatic check_snapshot(input int ch, input longint exp_bits, input longint exp_errs);
    xcvr_rcfg_pkg::user_data_t rdata;
    for (int i = 0; i < xcvr_rcfg_pkg::PRBS_SNAP_BYTES; i++) begin
      user_read(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_PRBS_BIT_BASE + i), rdata);
      check_data(rdata, 32'((exp_bits >> (8 * i)) & 8'hFF), "PRBS bit snapshot byte");
      user_read(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_PRBS_ERR_BASE + i), rdata);
      check_data(rdata, 32'((exp_errs >> (8 * i)) & 8'hFF), "PRBS error snapshot byte");
    end
  endtask

  task automatic test_prbs_counting();
    int ch;
    int cycles;
    int err_cycles;
    int clr_before;
    bit err_bit;
    xcvr_rcfg_pkg::user_data_t rdata;
    ch         = $urandom % NCH;
    cycles     = 20 + ($urandom % 41);
    err_cycles = 0;
    user_write(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_PRBS_CTRL), 32'h1);
    user_read(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_PRBS_CTRL), rdata);
    check_data(rdata, 32'h1, "PRBS_CTRL with count_en set");
    for (int i = 0; i < cycles; i++) begin
      @(negedge reconfig_clk);
      err_bit       = 1'($urandom);
      prbs_done[ch] = 1'b1;
      prbs_err[ch]  = err_bit;
      if (err_bit) err_cycles++;
    end
    @(negedge reconfig_clk);
    prbs_done[ch] = 1'b0;
    prbs_err[ch]  = 1'b0;
    repeat (4) @(negedge reconfig_clk);
    user_write(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_PRBS_CTRL), 32'h4);
    check_snapshot(ch, cycles, err_cycles);
    clr_before = clr_pulses[ch];
    user_write(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_PRBS_CTRL), 32'h2);
    repeat (2) @(negedge reconfig_clk);
    check_data(32'(clr_pulses[ch] - clr_before), 32'h1, "prbs_err_clr pulse count");
    user_write(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_PRBS_CTRL), 32'h4);
    check_snapshot(ch, 0, 0);
    // Synced done shows in bit 3 while count_en stays cleared
    @(negedge reconfig_clk);
    prbs_done[ch] = 1'b1;
    repeat (3) @(negedge reconfig_clk);
    user_read(make_csr_addr(ch, xcvr_rcfg_pkg::CSR_ADDR_PRBS_CTRL), rdata);
    check_data(rdata, 32'h8, "PRBS_CTRL done flag");
    prbs_done[ch] = 1'b0;
  endtask

  initial begin
    seed_value  = $urandom(RANDOM_SEED);
    cycle_count = 0;
    reset       = 1'b1;
    user_req    = '0;
    prbs_err    = '0;
    prbs_done   = '0;
    for (int ch = 0; ch < NCH; ch++) begin
      status_in[ch]  = '0;
      ctrl_in[ch]    = '0;
      clr_pulses[ch] = 0;
    end
    repeat (5) @(negedge reconfig_clk);
    reset = 1'b0;

    test_phy_passthrough();
    test_channel_isolation();
    test_csr_identity();
    test_ctrl_override();
    test_prbs_counting();

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
common/xcvr_rcfg_pkg.sv
hw/prbs/prbs_accum.sv
hw/csr/soft_csr.sv
hw/xcvr_rcfg_channel.sv
hw/rcfg_channel_router.sv
hw/xcvr_rcfg_hub.sv
tests/phy_avmm_model.sv
tests/tb_xcvr_rcfg_hub.sv

//--- Bender.yml
package:
  name: xcvr_rcfg_hub

sources:
  - common/xcvr_rcfg_pkg.sv
  - hw/prbs/prbs_accum.sv
  - hw/csr/soft_csr.sv
  - hw/xcvr_rcfg_channel.sv
  - hw/rcfg_channel_router.sv
  - hw/xcvr_rcfg_hub.sv
  - target: test
    files:
      - tests/phy_avmm_model.sv
      - tests/tb_xcvr_rcfg_hub.sv
